//--- hw/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// byte address from the pipeline
`define ADDR_W 32

// pipeline word
`define XLEN 64

// one cache line, 32 bytes
`define LINE_W 256

// 64 sets
`define IDX_W 6
`define OFS_W 5
`define TAG_W 21

`define WAYS 2

// refill beats of XLEN bits per line
`define BEATS 4

`endif

//--- hw/cachePkg.sv
`default_nettype none

package cachePkg;

  // controller states
  // WRITEBACK is skipped for a clean or invalid victim
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    COMPARE   = 3'd1,
    WRITEBACK = 3'd2,
    MISS      = 3'd3,
    REFILL    = 3'd4,
    REPLACE   = 3'd5
  } cacheState_e;

  // pipeline request operation
  typedef enum logic {
    LOAD  = 1'b0,
    STORE = 1'b1
  } memOp_e;

endpackage

`default_nettype wire

//--- hw/csrPkg.sv
`default_nettype none

package csrPkg;

  // register map
  typedef enum logic [1:0] {
    CTRL   = 2'd0,
    HITS   = 2'd1,
    MISSES = 2'd2,
    WBACKS = 2'd3
  } csrReg_e;

  typedef enum logic {
    LRU         = 1'b0,
    ROUND_ROBIN = 1'b1
  } replPolicy_e;

endpackage

`default_nettype wire

//--- hw/arrayIf.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

interface arrayIf;
  logic [`IDX_W-1:0]              index;
  logic [`TAG_W-1:0]              tag;
  logic                           lookup;
  logic [`WAYS-1:0]               hit;
  logic                           vicWay;
  logic                           vicDirty;
  logic [`TAG_W-1:0]              vicTag;
  logic                           fill;
  logic                           fillWay;
  logic                           storeHit;
  logic                           storeWay;
  logic                           wrWay;
  logic                           wrEn;
  logic [`LINE_W/8-1:0]           wrBe;
  logic [`LINE_W-1:0]             wrLine;
  logic [`WAYS-1:0][`LINE_W-1:0]  rdLine;

  modport ctrl (
    output index, tag, lookup, fill, fillWay, storeHit, storeWay,
    output wrWay, wrEn, wrBe, wrLine,
    input  hit, vicWay, vicDirty, vicTag, rdLine
  );

  modport tags (
    input  index, tag, lookup, fill, fillWay, storeHit, storeWay,
    output hit, vicWay, vicDirty, vicTag
  );

  modport data (
    input  index, wrWay, wrEn, wrBe, wrLine,
    output rdLine
  );
endinterface

`default_nettype wire

//--- hw/tagStore.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module tagStore import csrPkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  replPolicy_e policy_i,
  arrayIf.tags        arr
);

  localparam int SETS = 1 << `IDX_W;

  logic [`TAG_W-1:0]          tagMem [`WAYS][SETS];
  logic [SETS-1:0][`WAYS-1:0] validQ;
  logic [SETS-1:0][`WAYS-1:0] dirtyQ;
  // way to evict next under LRU
  logic [SETS-1:0]            lruQ;
  logic [SETS-1:0]            rrPtrQ;
  logic [`IDX_W-1:0]          idxQ;
  logic                       hitWay;

  // index registered like the data array, so lookups line up with its read data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idxQ <= '0;
    end else begin
      idxQ <= arr.index;
    end
  end

  always_comb begin
    for (int w = 0; w < `WAYS; w++) begin
      arr.hit[w] = validQ[idxQ][w] && (tagMem[w][idxQ] == arr.tag);
    end
  end

  assign hitWay = arr.hit[1];

  // invalid ways first, way 0 before way 1
  always_comb begin
    if (!validQ[idxQ][0]) begin
      arr.vicWay = 1'b0;
    end else if (!validQ[idxQ][1]) begin
      arr.vicWay = 1'b1;
    end else if (policy_i == ROUND_ROBIN) begin
      arr.vicWay = rrPtrQ[idxQ];
    end else begin
      arr.vicWay = lruQ[idxQ];
    end
  end

  assign arr.vicDirty = dirtyQ[idxQ][arr.vicWay];
  assign arr.vicTag   = tagMem[arr.vicWay][idxQ];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
      lruQ   <= '0;
      rrPtrQ <= '0;
    end else if (arr.fill) begin
      validQ[idxQ][arr.fillWay] <= 1'b1;
      dirtyQ[idxQ][arr.fillWay] <= 1'b0;
      // filled way becomes most recently used
      lruQ[idxQ]   <= ~arr.fillWay;
      rrPtrQ[idxQ] <= ~rrPtrQ[idxQ];
    end else if (arr.lookup) begin
      if (|arr.hit) begin
        lruQ[idxQ] <= ~hitWay;
      end
      if (arr.storeHit) begin
        dirtyQ[idxQ][arr.storeWay] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arr.fill) begin
      tagMem[arr.fillWay][idxQ] <= arr.tag;
    end
  end

  // a line lives in one way only, so refills never duplicate a tag
  oneWayHit: assert property (@(posedge clk) disable iff (!rst_n)
    arr.lookup |-> $onehot0(arr.hit));

endmodule

`default_nettype wire

//--- hw/dataArray.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dataArray (
  input logic  clk,
  arrayIf.data arr
);

  localparam int SETS = 1 << `IDX_W;
  localparam int BE_W = `LINE_W / 8;

  logic [`LINE_W-1:0] mem [`WAYS][SETS];

  // byte masked write into one way
  always_ff @(posedge clk) begin
    if (arr.wrEn) begin
      for (int b = 0; b < BE_W; b++) begin
        if (arr.wrBe[b]) begin
          mem[arr.wrWay][arr.index][b*8 +: 8] <= arr.wrLine[b*8 +: 8];
        end
      end
    end
  end

  // both ways read every cycle
  // a write in the same cycle is not visible until the next read
  always_ff @(posedge clk) begin
    for (int w = 0; w < `WAYS; w++) begin
      arr.rdLine[w] <= mem[w][arr.index];
    end
  end

endmodule

`default_nettype wire

//--- hw/cacheCtrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module cacheCtrl import cachePkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  // pipeline
  input  logic                reqValid_i,
  input  memOp_e              reqOp_i,
  input  logic [`ADDR_W-1:0]  reqAddr_i,
  input  logic [`XLEN-1:0]    reqWrData_i,
  input  logic [`XLEN/8-1:0]  reqWrMask_i,
  output logic                addrOk_o,
  output logic                dataOk_o,
  output logic [`XLEN-1:0]    rdData_o,
  // memory
  output logic                memRdValid_o,
  output logic [`ADDR_W-1:0]  memRdAddr_o,
  input  logic                memRdReady_i,
  input  logic [`XLEN-1:0]    memRdData_i,
  input  logic                memRdDataValid_i,
  input  logic                memRdLast_i,
  output logic                memWrValid_o,
  output logic [`ADDR_W-1:0]  memWrAddr_o,
  output logic [`LINE_W-1:0]  memWrData_o,
  input  logic                memWrReady_i,
  // event pulses
  output logic                hitEvt_o,
  output logic                missEvt_o,
  output logic                wbackEvt_o,
  arrayIf.ctrl                arr
);

  localparam int MASK_W = `XLEN / 8;
  localparam int BE_W   = `LINE_W / 8;
  localparam int TAG_LO = `OFS_W + `IDX_W;

  cacheState_e                  stateQ;
  cacheState_e                  stateD;
  memOp_e                       opQ;
  logic [`ADDR_W-1:0]           addrQ;
  logic [`XLEN-1:0]             wrDataQ;
  logic [MASK_W-1:0]            wrMaskQ;
  logic [`LINE_W-1:0]           refillBuf;
  logic [$clog2(`BEATS)-1:0]    beatCnt;
  logic                         retryQ;
  logic                         vicWayQ;
  logic [`TAG_W-1:0]            vicTagQ;
  logic                         accept;
  logic                         anyHit;
  logic                         hitWay;
  logic                         inCompare;
  logic [`IDX_W-1:0]            idxQ;
  logic [`TAG_W-1:0]            tagQ;
  logic [1:0]                   wordSel;
  logic [`LINE_W-1:0]           hitLine;

  assign idxQ      = addrQ[TAG_LO-1:`OFS_W];
  assign tagQ      = addrQ[`ADDR_W-1:TAG_LO];
  assign wordSel   = addrQ[`OFS_W-1:3];
  assign inCompare = (stateQ == COMPARE);
  assign anyHit    = |arr.hit;
  assign hitWay    = arr.hit[1];

  // a load hit frees the port for the next request
  assign addrOk_o = (stateQ == IDLE) || (inCompare && anyHit && opQ == LOAD);
  assign accept   = reqValid_i && addrOk_o;
  assign dataOk_o = inCompare && anyHit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ  <= IDLE;
      opQ     <= LOAD;
      retryQ  <= 1'b0;
      vicWayQ <= 1'b0;
      beatCnt <= '0;
    end else begin
      stateQ <= stateD;
      // marks the COMPARE right after a refill
      retryQ <= (stateQ == REPLACE);
      if (accept) begin
        opQ <= reqOp_i;
      end
      if (inCompare && !anyHit) begin
        vicWayQ <= arr.vicWay;
      end
      if (stateQ == MISS) begin
        beatCnt <= '0;
      end else if (stateQ == REFILL && memRdDataValid_i) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addrQ   <= reqAddr_i;
      wrDataQ <= reqWrData_i;
      wrMaskQ <= reqWrMask_i;
    end
    if (inCompare && !anyHit) begin
      vicTagQ <= arr.vicTag;
    end
    if (stateQ == REFILL && memRdDataValid_i) begin
      refillBuf[beatCnt*`XLEN +: `XLEN] <= memRdData_i;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      IDLE: begin
        if (accept) begin
          stateD = COMPARE;
        end
      end
      COMPARE: begin
        if (anyHit) begin
          stateD = accept ? COMPARE : IDLE;
        end else begin
          stateD = arr.vicDirty ? WRITEBACK : MISS;
        end
      end
      WRITEBACK: begin
        if (memWrReady_i) begin
          stateD = MISS;
        end
      end
      MISS: begin
        if (memRdReady_i) begin
          stateD = REFILL;
        end
      end
      REFILL: begin
        if (memRdLast_i) begin
          stateD = REPLACE;
        end
      end
      REPLACE: stateD = COMPARE;
      default: stateD = IDLE;
    endcase
  end

  // the array still holds the old line in the retry cycle
  always_comb begin
    hitLine  = retryQ ? refillBuf : arr.rdLine[hitWay];
    rdData_o = hitLine[wordSel*`XLEN +: `XLEN];
  end

  // new index goes out at accept so the data is ready in COMPARE
  assign arr.index    = accept ? reqAddr_i[TAG_LO-1:`OFS_W] : idxQ;
  assign arr.tag      = tagQ;
  assign arr.lookup   = inCompare;
  assign arr.fill     = (stateQ == REPLACE);
  assign arr.fillWay  = vicWayQ;
  assign arr.storeHit = inCompare && anyHit && opQ == STORE;
  assign arr.storeWay = hitWay;
  assign arr.wrEn     = arr.fill || arr.storeHit;
  assign arr.wrWay    = arr.fill ? vicWayQ : hitWay;
  // store data copied to every word, byte enables pick the addressed one
  assign arr.wrLine   = arr.fill ? refillBuf : {`BEATS{wrDataQ}};
  assign arr.wrBe     = arr.fill ? {BE_W{1'b1}} :
                        {{(BE_W-MASK_W){1'b0}}, wrMaskQ} << (wordSel * MASK_W);

  assign memWrValid_o = (stateQ == WRITEBACK);
  assign memWrAddr_o  = {vicTagQ, idxQ, {`OFS_W{1'b0}}};
  assign memWrData_o  = arr.rdLine[vicWayQ];
  assign memRdValid_o = (stateQ == MISS);
  assign memRdAddr_o  = {tagQ, idxQ, {`OFS_W{1'b0}}};

  // retry COMPARE is not a new request
  assign hitEvt_o   = inCompare && anyHit && !retryQ;
  assign missEvt_o  = inCompare && !anyHit && !retryQ;
  assign wbackEvt_o = memWrValid_o && memWrReady_i;

  memOneDir: assert property (@(posedge clk) disable iff (!rst_n)
    !(memRdValid_o && memWrValid_o));

  // COMPARE is only entered from an accept or a refill
  dataOkCmp: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_o |-> inCompare && ($past(accept) || $past(stateQ) == REPLACE));

  lastInRefill: assert property (@(posedge clk) disable iff (!rst_n)
    memRdLast_i |-> stateQ == REFILL && memRdDataValid_i);

endmodule

`default_nettype wire

//--- hw/cacheCsr.sv
`timescale 1ns/1ps
`default_nettype none

module cacheCsr import csrPkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        regWrEn_i,
  input  csrReg_e     regAddr_i,
  input  logic [31:0] regWrData_i,
  output logic [31:0] regRdData_o,
  input  logic        hitEvt_i,
  input  logic        missEvt_i,
  input  logic        wbackEvt_i,
  output replPolicy_e policy_o
);

  localparam int CNT_W   = 32;
  localparam int NUM_CNT = 3;

  replPolicy_e       policyQ;
  logic [NUM_CNT-1:0] evt;
  // hits, misses, writebacks at register addresses 1 to 3
  logic [CNT_W-1:0]  cnt [NUM_CNT];

  assign evt      = {wbackEvt_i, missEvt_i, hitEvt_i};
  assign policy_o = policyQ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      policyQ <= LRU;
    end else if (regWrEn_i && regAddr_i == CTRL) begin
      policyQ <= replPolicy_e'(regWrData_i[0]);
    end
  end

  // write clears, otherwise count and stick at all ones
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CNT; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        if (regWrEn_i && regAddr_i == csrReg_e'(i + 1)) begin
          cnt[i] <= '0;
        end else if (evt[i] && cnt[i] != {CNT_W{1'b1}}) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    case (regAddr_i)
      CTRL:    regRdData_o = {{(CNT_W-1){1'b0}}, policyQ};
      HITS:    regRdData_o = cnt[0];
      MISSES:  regRdData_o = cnt[1];
      WBACKS:  regRdData_o = cnt[2];
      default: regRdData_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/dcacheTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module dcacheTop import cachePkg::*, csrPkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  // pipeline
  input  logic                reqValid_i,
  input  memOp_e              reqOp_i,
  input  logic [`ADDR_W-1:0]  reqAddr_i,
  input  logic [`XLEN-1:0]    reqWrData_i,
  input  logic [`XLEN/8-1:0]  reqWrMask_i,
  output logic                addrOk_o,
  output logic                dataOk_o,
  output logic [`XLEN-1:0]    rdData_o,
  // memory
  output logic                memRdValid_o,
  output logic [`ADDR_W-1:0]  memRdAddr_o,
  input  logic                memRdReady_i,
  input  logic [`XLEN-1:0]    memRdData_i,
  input  logic                memRdDataValid_i,
  input  logic                memRdLast_i,
  output logic                memWrValid_o,
  output logic [`ADDR_W-1:0]  memWrAddr_o,
  output logic [`LINE_W-1:0]  memWrData_o,
  input  logic                memWrReady_i,
  // registers
  input  logic                regWrEn_i,
  input  csrReg_e             regAddr_i,
  input  logic [31:0]         regWrData_i,
  output logic [31:0]         regRdData_o
);

  logic        hitEvt;
  logic        missEvt;
  logic        wbackEvt;
  replPolicy_e policy;

  arrayIf arr ();

  cacheCtrl uCtrl (
    .clk, .rst_n,
    .reqValid_i, .reqOp_i, .reqAddr_i, .reqWrData_i, .reqWrMask_i,
    .addrOk_o, .dataOk_o, .rdData_o,
    .memRdValid_o, .memRdAddr_o, .memRdReady_i,
    .memRdData_i, .memRdDataValid_i, .memRdLast_i,
    .memWrValid_o, .memWrAddr_o, .memWrData_o, .memWrReady_i,
    .hitEvt_o(hitEvt), .missEvt_o(missEvt), .wbackEvt_o(wbackEvt),
    .arr(arr)
  );

  tagStore uTags (.clk, .rst_n, .policy_i(policy), .arr(arr));

  dataArray uData (.clk, .arr(arr));

  cacheCsr uCsr (
    .clk, .rst_n,
    .regWrEn_i, .regAddr_i, .regWrData_i, .regRdData_o,
    .hitEvt_i(hitEvt), .missEvt_i(missEvt), .wbackEvt_i(wbackEvt),
    .policy_o(policy)
  );

endmodule

`default_nettype wire

//--- tb/tbDcache.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_consts.svh"

module tbDcache import cachePkg::*, csrPkg::*; ();

  localparam int PHASE_REQ  = 150;
  localparam int MISS_BOUND = 64;
  localparam int TAG_LO     = `OFS_W + `IDX_W;
  localparam int TIMEOUT_NS = (2 * PHASE_REQ * MISS_BOUND + 400) * 10;

  typedef struct packed {
    logic        isLoad;
    logic        hit;
    logic [63:0] data;
    logic [31:0] lineAddr;
    logic [31:0] cyc;
  } reqRec_t;

  logic clk;
  logic rst_n;
  logic reqValid_i;
  memOp_e reqOp_i;
  logic [`ADDR_W-1:0] reqAddr_i;
  logic [`XLEN-1:0] reqWrData_i;
  logic [`XLEN/8-1:0] reqWrMask_i;
  logic addrOk_o;
  logic dataOk_o;
  logic [`XLEN-1:0] rdData_o;
  logic memRdValid_o;
  logic [`ADDR_W-1:0] memRdAddr_o;
  logic memRdReady_i;
  logic [`XLEN-1:0] memRdData_i;
  logic memRdDataValid_i;
  logic memRdLast_i;
  logic memWrValid_o;
  logic [`ADDR_W-1:0] memWrAddr_o;
  logic [`LINE_W-1:0] memWrData_o;
  logic memWrReady_i;
  logic regWrEn_i;
  csrReg_e regAddr_i;
  logic [31:0] regWrData_i;
  logic [31:0] regRdData_o;

  logic [31:0] lfsr = 32'd74;
  int unsigned errCount = 0;
  int unsigned reqCount = 0;
  logic [31:0] cyc = '0;
  logic [7:0] refMem [logic [31:0]];
  logic [7:0] respMem [logic [31:0]];
  reqRec_t pend [$];
  logic [31:0] wbAddrQ [$];
  logic [`LINE_W-1:0] wbLineQ [$];
  // mirror of the tag store
  logic [`TAG_W-1:0] mTag [64][2];
  logic [1:0] mValid [64];
  logic [1:0] mDirty [64];
  logic mLru [64];
  logic mRr [64];
  logic mPolicy = 1'b0;
  logic [31:0] mHits = '0;
  logic [31:0] mMisses = '0;
  logic [31:0] mWbacks = '0;
  logic rdHeld = 1'b0;
  logic [31:0] rdHeldAddr = '0;
  logic wrHeld = 1'b0;
  logic [31:0] wrHeldAddr = '0;

  dcacheTop dut (.*);

  always #5 clk = ~clk;

  function automatic logic [63:0] randBits(input int n);
    logic [63:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  // initial memory contents, every address bit mixed in
  function automatic logic [7:0] fillByte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [7:0] refByte(input logic [31:0] a);
    return refMem.exists(a) ? refMem[a] : fillByte(a);
  endfunction

  function automatic logic [7:0] respByte(input logic [31:0] a);
    return respMem.exists(a) ? respMem[a] : fillByte(a);
  endfunction

  // follows the tag store rules at each accept, in request order
  task automatic predictAccept();
    reqRec_t r;
    logic [`IDX_W-1:0] idx;
    logic [`TAG_W-1:0] tg;
    logic [1:0] hits;
    logic v;
    logic [31:0] wa;
    logic [`LINE_W-1:0] line;
    idx = reqAddr_i[TAG_LO-1:`OFS_W];
    tg = reqAddr_i[`ADDR_W-1:TAG_LO];
    hits[0] = mValid[idx][0] && mTag[idx][0] == tg;
    hits[1] = mValid[idx][1] && mTag[idx][1] == tg;
    r.isLoad = (reqOp_i == LOAD);
    r.hit = |hits;
    r.lineAddr = {reqAddr_i[`ADDR_W-1:`OFS_W], 5'b0};
    r.cyc = cyc;
    if (r.hit) begin
      mHits++;
      v = hits[1];
    end else begin
      mMisses++;
      if (!mValid[idx][0]) v = 1'b0;
      else if (!mValid[idx][1]) v = 1'b1;
      else v = mPolicy ? mRr[idx] : mLru[idx];
      if (mDirty[idx][v]) begin
        mWbacks++;
        wa = {mTag[idx][v], idx, 5'b0};
        for (int b = 0; b < 32; b++) line[b*8 +: 8] = refByte(wa + b);
        wbAddrQ.push_back(wa);
        wbLineQ.push_back(line);
      end
      mValid[idx][v] = 1'b1;
      mDirty[idx][v] = 1'b0;
      mTag[idx][v] = tg;
      mRr[idx] = ~mRr[idx];
    end
    mLru[idx] = ~v;
    if (!r.isLoad) begin
      mDirty[idx][v] = 1'b1;
      for (int b = 0; b < 8; b++) begin
        if (reqWrMask_i[b]) refMem[reqAddr_i + b] = reqWrData_i[b*8 +: 8];
      end
    end
    for (int b = 0; b < 8; b++) r.data[b*8 +: 8] = refByte(reqAddr_i + b);
    pend.push_back(r);
  endtask

  always @(posedge clk) begin : monitor
    reqRec_t head;
    if (rst_n) begin
      cyc++;
      if (rdHeld) assert (memRdValid_o && memRdAddr_o == rdHeldAddr) else begin
        errCount++;
        $display("memory read request dropped or changed before ready at %0t", $time);
      end
      if (wrHeld) assert (memWrValid_o && memWrAddr_o == wrHeldAddr) else begin
        errCount++;
        $display("memory write request dropped or changed before ready at %0t", $time);
      end
      if (dataOk_o) begin
        assert (pend.size() != 0) else begin
          errCount++;
          $display("dataOk seen with no accepted request at %0t", $time);
        end
        if (pend.size() != 0) begin
          head = pend.pop_front();
          if (head.hit) assert (cyc == head.cyc + 1) else begin
            errCount++;
            $display("[FAIL] %0t: hit took %0d cycles", $time, cyc - head.cyc);
          end
          else assert (cyc > head.cyc + 1) else begin
            errCount++;
            $display("[FAIL] %0t: predicted miss answered as a hit", $time);
          end
          // only a load completion leaves the port open
          assert (addrOk_o == head.isLoad) else begin
            errCount++;
            $display("[FAIL] %0t: addrOk %b at completion of isLoad %b", $time,
                     addrOk_o, head.isLoad);
          end
          if (head.isLoad) assert (rdData_o == head.data) else begin
            errCount++;
            $display("[FAIL] %0t: load %h got %h exp %h", $time, head.lineAddr,
                     rdData_o, head.data);
          end
          assert (wbAddrQ.size() == 0) else begin
            errCount++;
            $display("expected writeback never arrived at %0t", $time);
          end
        end
      end else if (pend.size() != 0 && !pend[0].hit) begin
        assert (!addrOk_o) else begin
          errCount++;
          $display("addrOk high during an outstanding miss at %0t", $time);
        end
      end
      if (memWrValid_o && memWrReady_i) begin
        assert (wbAddrQ.size() != 0) else begin
          errCount++;
          $display("unexpected memory write at %0t", $time);
        end
        if (wbAddrQ.size() != 0) begin
          assert (memWrAddr_o == wbAddrQ[0] && memWrData_o == wbLineQ[0]) else begin
            errCount++;
            $display("[FAIL] %0t: writeback %h exp %h or line differs", $time,
                     memWrAddr_o, wbAddrQ[0]);
          end
          void'(wbAddrQ.pop_front());
          void'(wbLineQ.pop_front());
        end
      end
      if (memRdValid_o && memRdReady_i) begin
        assert (wbAddrQ.size() == 0 && pend.size() != 0 && !pend[0].hit &&
                memRdAddr_o == pend[0].lineAddr) else begin
          errCount++;
          $display("[FAIL] %0t: refill read %h not the predicted miss", $time, memRdAddr_o);
        end
      end
      if (reqValid_i && addrOk_o) predictAccept();
      rdHeld = memRdValid_o && !memRdReady_i;
      rdHeldAddr = memRdAddr_o;
      wrHeld = memWrValid_o && !memWrReady_i;
      wrHeldAddr = memWrAddr_o;
    end
  end

  // memory side with random ready and beat delays
  initial begin : responder
    logic [31:0] a;
    forever begin
      @(negedge clk);
      if (memWrValid_o) begin
        repeat (randBits(2)) @(negedge clk);
        memWrReady_i = 1'b1;
        for (int b = 0; b < 32; b++) respMem[memWrAddr_o + b] = memWrData_o[b*8 +: 8];
        @(negedge clk);
        memWrReady_i = 1'b0;
      end else if (memRdValid_o) begin
        a = memRdAddr_o;
        repeat (randBits(2)) @(negedge clk);
        memRdReady_i = 1'b1;
        @(negedge clk);
        memRdReady_i = 1'b0;
        for (int k = 0; k < `BEATS; k++) begin
          repeat (randBits(1)) @(negedge clk);
          for (int b = 0; b < 8; b++) memRdData_i[b*8 +: 8] = respByte(a + k*8 + b);
          memRdDataValid_i = 1'b1;
          memRdLast_i = (k == `BEATS - 1);
          @(negedge clk);
          memRdDataValid_i = 1'b0;
          memRdLast_i = 1'b0;
        end
      end
    end
  end

  task automatic regRead(input csrReg_e a, output logic [31:0] v);
    @(negedge clk);
    regAddr_i = a;
    #1;
    v = regRdData_o;
  endtask

  task automatic regWrite(input csrReg_e a, input logic [31:0] d);
    @(negedge clk);
    regWrEn_i = 1'b1;
    regAddr_i = a;
    regWrData_i = d;
    @(negedge clk);
    regWrEn_i = 1'b0;
  endtask

  task automatic checkReg(input csrReg_e a, input logic [31:0] expV);
    logic [31:0] v;
    regRead(a, v);
    assert (v == expV) else begin
      errCount++;
      $display("[FAIL] %0t: register %s got %0d exp %0d", $time, a.name(), v, expV);
    end
  endtask

  // counters against the model, then clear each
  task automatic checkCounters();
    checkReg(HITS, mHits);
    checkReg(MISSES, mMisses);
    checkReg(WBACKS, mWbacks);
    regWrite(HITS, 32'd0);
    checkReg(HITS, 32'd0);
    checkReg(MISSES, mMisses);
    regWrite(MISSES, 32'd0);
    checkReg(MISSES, 32'd0);
    checkReg(WBACKS, mWbacks);
    regWrite(WBACKS, 32'd0);
    checkReg(WBACKS, 32'd0);
    checkReg(HITS, 32'd0);
    mHits = '0;
    mMisses = '0;
    mWbacks = '0;
  endtask

  // small tag and set pool, so conflicts and dirty evictions are common
  task automatic runRequests(input int n);
    logic [1:0] ts;
    logic [1:0] ss;
    logic [1:0] ws;
    @(negedge clk);
    for (int i = 0; i < n; i++) begin
      ts = 2'(randBits(2));
      ss = 2'(randBits(2));
      ws = 2'(randBits(2));
      reqAddr_i = {21'h0a5 + 21'(ts) * 21'h111, ss, 4'b0011, ws, 3'b000};
      reqOp_i = memOp_e'(randBits(1));
      reqWrData_i = randBits(64);
      reqWrMask_i = 8'(randBits(8));
      reqValid_i = 1'b1;
      while (!addrOk_o) @(negedge clk);
      @(negedge clk);
      reqValid_i = 1'b0;
      reqCount++;
      if (randBits(2) == 0) @(negedge clk);
    end
    while (pend.size() != 0) @(negedge clk);
  endtask

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("watchdog timeout, requests did not complete");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : stimulus
    clk = 1'b0;
    rst_n = 1'b0;
    reqValid_i = 1'b0;
    reqOp_i = LOAD;
    reqAddr_i = '0;
    reqWrData_i = '0;
    reqWrMask_i = '0;
    memRdReady_i = 1'b0;
    memRdData_i = '0;
    memRdDataValid_i = 1'b0;
    memRdLast_i = 1'b0;
    memWrReady_i = 1'b0;
    regWrEn_i = 1'b0;
    regAddr_i = CTRL;
    regWrData_i = '0;
    for (int s = 0; s < 64; s++) begin
      mValid[s] = '0;
      mDirty[s] = '0;
      mLru[s] = 1'b0;
      mRr[s] = 1'b0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    assert (addrOk_o && !dataOk_o && !memRdValid_o && !memWrValid_o) else begin
      errCount++;
      $display("pipeline or memory handshake not idle after reset");
    end
    checkReg(CTRL, 32'd0);
    checkReg(HITS, 32'd0);
    checkReg(MISSES, 32'd0);
    checkReg(WBACKS, 32'd0);
    runRequests(PHASE_REQ);
    checkCounters();
    regWrite(CTRL, 32'd1);
    mPolicy = 1'b1;
    checkReg(CTRL, 32'd1);
    runRequests(PHASE_REQ);
    checkCounters();
    $display("requests=%0d errors=%0d", reqCount, errCount);
    if (errCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/cachePkg.sv
hw/csrPkg.sv
hw/arrayIf.sv
hw/tagStore.sv
hw/dataArray.sv
hw/cacheCtrl.sv
hw/cacheCsr.sv
hw/dcacheTop.sv
tb/tbDcache.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbDcache \
  -f all.f --Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  echo "test failed"
  exit 1
fi

echo "test passed"
exit 0
